// File: compile.f
floor_pkg.sv
request_intake.sv
floor_request_cell.sv
dispatch_and_door_control.sv
floor_logic_control_unit.sv
tb_floor_logic.sv

// File: dispatch_and_door_control.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_and_door_control
    import floor_pkg::*;
(
    input  wire  floor_mask_t pending,
    input  wire  floor_t      current_floor_state,
    input  wire  car_state_t  elevator_state,
    input  wire               elevator_direction,
    input  wire               power_switch,
    input  wire               emergency_btn,
    input  wire               door_open_btn,
    input  wire               door_close_btn,
    output floor_mask_t       arrive_clear,
    output floor_t            elevator_floor_selector,
    output logic              direction_selector,
    output logic              activate_elevator,
    output logic              door_open_allowed,
    output logic              door_close_allowed
);

    logic        stopped;
    logic        in_service;
    logic        serve;
    floor_mask_t at_mask;
    floor_mask_t above_mask;
    floor_mask_t below_mask;
    logic        has_above;
    logic        has_below;
    floor_t      lowest_above;
    floor_t      highest_below;
    floor_t      target;

    ////////////////////
    // Car status decode
    ////////////////////

    // Stop codes form one contiguous range starting at zero
    assign stopped    = (elevator_state <= last_stop_state);
    assign in_service = stopped && power_switch;

    ////////////////////
    // Pending split
    ////////////////////

    // Partition requests around the current floor
    always_comb begin
        for (int i = 0; i < num_floors; i++) begin
            at_mask[i]    = (current_floor_state == floor_t'(i));
            above_mask[i] = pending[i] && (floor_t'(i) > current_floor_state);
            below_mask[i] = pending[i] && (floor_t'(i) < current_floor_state);
        end
    end

    assign has_above = |above_mask;
    assign has_below = |below_mask;

    // Nearest request above
    // Scanning top down leaves the lowest hit
    always_comb begin
        lowest_above = '0;
        for (int i = num_floors - 1; i >= 0; i--) begin
            if (above_mask[i]) begin
                lowest_above = floor_t'(i);
            end
        end
    end

    // Nearest request below, scanning bottom up
    always_comb begin
        highest_below = '0;
        for (int i = 0; i < num_floors; i++) begin
            if (below_mask[i]) begin
                highest_below = floor_t'(i);
            end
        end
    end

    ////////////////////
    // Target selection
    ////////////////////

    // Only dispatch from a stop with somewhere else to go
    assign serve = in_service && !emergency_btn && (has_above || has_below);

    // Keep going the same way if possible, else turn around
    always_comb begin
        if ((elevator_direction == dir_up) && has_above) begin
            target = lowest_above;
        end else if (has_below) begin
            target = highest_below;
        end else begin
            target = lowest_above;
        end
    end

    always_comb begin
        if (serve) begin
            elevator_floor_selector = target;
            direction_selector      = (target > current_floor_state) ? dir_up : !dir_up;
            activate_elevator       = 1'b1;
        end else begin
            // Idle or emergency, hold the car where it is
            elevator_floor_selector = current_floor_state;
            direction_selector      = elevator_direction;
            activate_elevator       = 1'b0;
        end
    end

    ////////////////////
    // Arrival and doors
    ////////////////////

    // Requests of the floor the car sits at are served
    assign arrive_clear = at_mask & {num_floors{in_service}};

    assign door_open_allowed  = in_service && door_open_btn;
    assign door_close_allowed = in_service && door_close_btn;

endmodule

`default_nettype wire

// File: floor_logic_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module floor_logic_control_unit
    import floor_pkg::*;
(
    input  wire  clock,
    input  wire  reset_n,
    input  wire  floor_mask_t floor_call_buttons,
    input  wire  floor_mask_t panel_buttons,
    input  wire  door_open_btn,
    input  wire  door_close_btn,
    input  wire  emergency_btn,
    input  wire  power_switch,
    input  wire  floor_t      current_floor_state,
    input  wire  car_state_t  elevator_state,
    input  wire  elevator_direction,
    output wire  floor_t      elevator_floor_selector,
    output wire  direction_selector,
    output wire  activate_elevator,
    output wire  floor_mask_t call_button_lights,
    output wire  floor_mask_t panel_button_lights,
    output wire  door_open_allowed,
    output wire  door_close_allowed
);

    wire floor_mask_t set_call;
    wire floor_mask_t set_panel;
    wire              clear_all;
    wire floor_mask_t arrive_clear;
    wire floor_mask_t pending_mask;

    ////////////////////
    // Button intake
    ////////////////////

    request_intake request_intake_i (
        .floor_call_buttons (floor_call_buttons),
        .panel_buttons      (panel_buttons),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .current_floor_state(current_floor_state),
        .set_call           (set_call),
        .set_panel          (set_panel),
        .clear_all          (clear_all)
    );

    ////////////////////
    // Per-floor requests
    ////////////////////

    for (genvar g = 0; g < num_floors; g++) begin : floor_cells
        floor_request_cell floor_request_cell_i (
            .clock       (clock),
            .reset_n     (reset_n),
            .set_call    (set_call[g]),
            .set_panel   (set_panel[g]),
            .clear_all   (clear_all),
            .arrive_clear(arrive_clear[g]),
            .call_lamp   (call_button_lights[g]),
            .panel_lamp  (panel_button_lights[g]),
            .pending     (pending_mask[g])
        );
    end

    ////////////////////
    // Dispatch and doors
    ////////////////////

    dispatch_and_door_control dispatch_and_door_control_i (
        .pending                (pending_mask),
        .current_floor_state    (current_floor_state),
        .elevator_state         (elevator_state),
        .elevator_direction     (elevator_direction),
        .power_switch           (power_switch),
        .emergency_btn          (emergency_btn),
        .door_open_btn          (door_open_btn),
        .door_close_btn         (door_close_btn),
        .arrive_clear           (arrive_clear),
        .elevator_floor_selector(elevator_floor_selector),
        .direction_selector     (direction_selector),
        .activate_elevator      (activate_elevator),
        .door_open_allowed      (door_open_allowed),
        .door_close_allowed     (door_close_allowed)
    );

endmodule

`default_nettype wire

// File: floor_pkg.sv
`default_nettype none

package floor_pkg;

    ////////////////////
    // Building geometry
    ////////////////////

    // Number of served floors
    localparam int num_floors = 11;

    // Floor index where 0 is the lowest floor
    typedef logic [3:0] floor_t;

    // One bit per floor with bit 0 as the lowest floor
    typedef logic [num_floors-1:0] floor_mask_t;

    ////////////////////
    // Motion controller
    ////////////////////

    // State code reported by the motion controller
    typedef logic [5:0] car_state_t;

    // Highest code of the stopped-at-floor range
    // Codes 0 to 10 are the stops, anything above is travel or emergency
    localparam car_state_t last_stop_state = 6'd10;

    // Direction encoding, the opposite value means down
    localparam logic dir_up = 1'b1;

endpackage

`default_nettype wire

// File: floor_request_cell.sv
`timescale 1ns/1ps
`default_nettype none

module floor_request_cell (
    input  wire  clock,
    input  wire  reset_n,
    input  wire  set_call,
    input  wire  set_panel,
    input  wire  clear_all,
    input  wire  arrive_clear,
    output logic call_lamp,
    output logic panel_lamp,
    output logic pending
);

    ////////////////////
    // Request bits
    ////////////////////

    // Clear_all wins over arrival, arrival wins over a new press
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_lamp  <= 1'b0;
            panel_lamp <= 1'b0;
        end else if (clear_all) begin
            call_lamp  <= 1'b0;
            panel_lamp <= 1'b0;
        end else if (arrive_clear) begin
            // Car is stopped here so both requests are served
            call_lamp  <= 1'b0;
            panel_lamp <= 1'b0;
        end else begin
            if (set_call) begin
                call_lamp <= 1'b1;
            end
            if (set_panel) begin
                panel_lamp <= 1'b1;
            end
        end
    end

    // Floor wants service if either lamp is lit
    assign pending = call_lamp || panel_lamp;

endmodule

`default_nettype wire

// File: request_intake.sv
`timescale 1ns/1ps
`default_nettype none

module request_intake
    import floor_pkg::*;
(
    input  wire  floor_mask_t floor_call_buttons,
    input  wire  floor_mask_t panel_buttons,
    input  wire               power_switch,
    input  wire               emergency_btn,
    input  wire  floor_t      current_floor_state,
    output floor_mask_t       set_call,
    output floor_mask_t       set_panel,
    output logic              clear_all
);

    // Normal service means power on and no emergency
    logic        accept;
    floor_mask_t current_onehot;
    floor_mask_t accept_mask;

    ////////////////////
    // Service gating
    ////////////////////

    assign accept = power_switch && !emergency_btn;

    // One-hot of the occupied floor
    // Codes past the top floor decode to no floor at all
    always_comb begin
        for (int i = 0; i < num_floors; i++) begin
            current_onehot[i] = (current_floor_state == floor_t'(i));
        end
    end

    // A press at the occupied floor is dropped
    assign accept_mask = {num_floors{accept}} & ~current_onehot;

    ////////////////////
    // Set and clear strobes
    ////////////////////

    // Hall calls and car panel share the same gating
    assign set_call  = floor_call_buttons & accept_mask;
    assign set_panel = panel_buttons & accept_mask;

    // Losing power or pressing emergency wipes every request
    assign clear_all = !power_switch || emergency_btn;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the floor logic testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing \
    --top-module tb_floor_logic \
    -Mdir "$build_dir" \
    -f compile.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$build_dir/Vtb_floor_logic" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
fi

# The log decides the result
if grep -qx "TESTBENCH PASSED" "$log_file"; then
    echo "Result: pass"
    exit 0
fi

echo "Result: fail, see $log_file"
exit 1

// File: tb_floor_logic.sv
`timescale 1ns/1ps
`default_nettype none

module tb_floor_logic
    import floor_pkg::*;
();

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor_state;
    car_state_t  elevator_state;
    logic        elevator_direction;
    floor_t      elevator_floor_selector;
    logic        direction_selector;
    logic        activate_elevator;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    logic        door_open_allowed;
    logic        door_close_allowed;

    // Reference copy of the request lamps
    floor_mask_t model_call;
    floor_mask_t model_panel;
    logic [31:0] lfsr_state;

    floor_logic_control_unit floor_logic_control_unit_i (
        .clock                  (clock),
        .reset_n                (reset_n),
        .floor_call_buttons     (floor_call_buttons),
        .panel_buttons          (panel_buttons),
        .door_open_btn          (door_open_btn),
        .door_close_btn         (door_close_btn),
        .emergency_btn          (emergency_btn),
        .power_switch           (power_switch),
        .current_floor_state    (current_floor_state),
        .elevator_state         (elevator_state),
        .elevator_direction     (elevator_direction),
        .elevator_floor_selector(elevator_floor_selector),
        .direction_selector     (direction_selector),
        .activate_elevator      (activate_elevator),
        .call_button_lights     (call_button_lights),
        .panel_button_lights    (panel_button_lights),
        .door_open_allowed      (door_open_allowed),
        .door_close_allowed     (door_close_allowed)
    );

    always #5 clock = ~clock;

    ////////////////////
    // Helpers
    ////////////////////

    // Galois LFSR stepped once per bit handed out
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        logic        lsb;
        value = '0;
        for (int n = 0; n < count; n++) begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            value = {value[30:0], lsb};
        end
        return value;
    endfunction

    task automatic check_equal(input string what, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Next lamp state from the inputs present at the edge
    task automatic update_model();
        logic in_service;
        int   cur;
        cur        = int'(current_floor_state);
        in_service = power_switch && (elevator_state <= last_stop_state);
        for (int f = 0; f < num_floors; f++) begin
            if (!power_switch || emergency_btn || (in_service && f == cur)) begin
                model_call[f]  = 1'b0;
                model_panel[f] = 1'b0;
            end else if (f != cur) begin
                model_call[f]  = model_call[f] | floor_call_buttons[f];
                model_panel[f] = model_panel[f] | panel_buttons[f];
            end
        end
    endtask

    task automatic check_outputs();
        floor_mask_t pend;
        logic        in_service;
        logic        serve;
        logic        found_up;
        logic        found_down;
        floor_t      up_floor;
        floor_t      down_floor;
        floor_t      exp_sel;
        logic        exp_dir;
        int          cur;
        cur        = int'(current_floor_state);
        pend       = model_call | model_panel;
        in_service = power_switch && (elevator_state <= last_stop_state);
        found_up   = 1'b0;
        found_down = 1'b0;
        up_floor   = '0;
        down_floor = '0;
        // Walk outward from the car in each direction
        for (int f = cur + 1; f < num_floors; f++) begin
            if (!found_up && pend[f]) begin
                found_up = 1'b1;
                up_floor = floor_t'(f);
            end
        end
        for (int f = cur - 1; f >= 0; f--) begin
            if (!found_down && pend[f]) begin
                found_down = 1'b1;
                down_floor = floor_t'(f);
            end
        end
        serve   = in_service && !emergency_btn && (found_up || found_down);
        exp_sel = current_floor_state;
        exp_dir = elevator_direction;
        if (serve) begin
            if (elevator_direction == dir_up && found_up) begin
                exp_sel = up_floor;
            end else if (found_down) begin
                exp_sel = down_floor;
            end else begin
                exp_sel = up_floor;
            end
            exp_dir = (exp_sel > current_floor_state);
        end
        check_equal("call_button_lights", 16'(call_button_lights), 16'(model_call));
        check_equal("panel_button_lights", 16'(panel_button_lights), 16'(model_panel));
        check_equal("elevator_floor_selector", 16'(elevator_floor_selector), 16'(exp_sel));
        check_equal("direction_selector", 16'(direction_selector), 16'(exp_dir));
        check_equal("activate_elevator", 16'(activate_elevator), 16'(serve));
        check_equal("door_open_allowed", 16'(door_open_allowed),
                    16'(in_service && door_open_btn));
        check_equal("door_close_allowed", 16'(door_close_allowed),
                    16'(in_service && door_close_btn));
    endtask

    // Advance one clock edge and compare before new inputs go in
    task automatic step_cycle();
        @(posedge clock);
        #1;
        update_model();
        check_outputs();
    endtask

    task automatic wait_for_activate(input int limit);
        int count;
        count = 0;
        while (!activate_elevator && count < limit) begin
            step_cycle();
            count++;
        end
        if (!activate_elevator) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "activate_elevator did not rise within %0d cycles", limit);
        end
    endtask

    task automatic wait_for_lamps_clear(input int limit);
        int count;
        count = 0;
        while ((call_button_lights | panel_button_lights) != '0 && count < limit) begin
            step_cycle();
            count++;
        end
        if ((call_button_lights | panel_button_lights) != '0) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "request lamps stayed lit for %0d cycles", limit);
        end
    endtask

    task automatic drive_random_inputs();
        for (int f = 0; f < num_floors; f++) begin
            floor_call_buttons[f] = (rand_bits(3) == 0);
            panel_buttons[f]      = (rand_bits(3) == 0);
        end
        current_floor_state = floor_t'(rand_bits(4) % 11);
        if (rand_bits(1) != 0) begin
            elevator_state = car_state_t'(rand_bits(4) % 11);
        end else begin
            elevator_state = car_state_t'(11 + rand_bits(6) % 53);
        end
        elevator_direction = (rand_bits(1) != 0);
        door_open_btn      = (rand_bits(1) != 0);
        door_close_btn     = (rand_bits(1) != 0);
        emergency_btn      = (rand_bits(5) == 0);
        power_switch       = (rand_bits(6) != 0);
    endtask

    ////////////////////
    // Sequence
    ////////////////////

    initial begin
        clock               = 1'b0;
        reset_n             = 1'b0;
        floor_call_buttons  = '0;
        panel_buttons       = '0;
        door_open_btn       = 1'b0;
        door_close_btn      = 1'b0;
        emergency_btn       = 1'b0;
        power_switch        = 1'b1;
        current_floor_state = 4'd2;
        elevator_state      = 6'd2;
        elevator_direction  = dir_up;
        model_call          = '0;
        model_panel         = '0;
        lfsr_state          = 32'd70913;

        repeat (2) @(posedge clock);
        #1;
        reset_n = 1'b1;
        check_outputs();

        // Hall call above and a panel press at the occupied floor
        floor_call_buttons = floor_mask_t'(1 << 7);
        panel_buttons      = floor_mask_t'(1 << 2);
        step_cycle();
        check_equal("lamp of floor 7", 16'(call_button_lights[7]), 16'd1);
        check_equal("lamp of occupied floor", 16'(panel_button_lights[2]), 16'd0);
        floor_call_buttons = '0;
        panel_buttons      = '0;
        wait_for_activate(4);

        // Request below while travelling leaves every lamp lit
        elevator_state      = 6'd30;
        current_floor_state = 4'd5;
        panel_buttons       = floor_mask_t'(1 << 0);
        step_cycle();
        panel_buttons = '0;

        // Stopped between the two requests going up and then down
        elevator_state = 6'd5;
        step_cycle();
        check_equal("target going up", 16'(elevator_floor_selector), 16'd7);
        elevator_direction = ~dir_up;
        step_cycle();
        check_equal("target going down", 16'(elevator_floor_selector), 16'd0);

        // Heading up from floor 9 with nothing above
        current_floor_state = 4'd9;
        elevator_state      = 6'd9;
        elevator_direction  = dir_up;
        step_cycle();
        check_equal("turnaround target", 16'(elevator_floor_selector), 16'd7);

        // Arrival at floor 7 serves it
        current_floor_state = 4'd7;
        elevator_state      = 6'd7;
        step_cycle();
        step_cycle();
        check_equal("served lamp", 16'(call_button_lights[7]), 16'd0);

        // Emergency holds the car while floor 0 is still pending
        floor_call_buttons = floor_mask_t'(1 << 4);
        emergency_btn      = 1'b1;
        #1;
        check_equal("activate in emergency", 16'(activate_elevator), 16'd0);
        check_outputs();

        // Emergency wipes the rest and blocks new presses
        wait_for_lamps_clear(4);
        step_cycle();

        // Power off ignores presses and door buttons
        emergency_btn  = 1'b0;
        power_switch   = 1'b0;
        door_open_btn  = 1'b1;
        door_close_btn = 1'b1;
        step_cycle();
        check_equal("door permit without power", 16'(door_open_allowed), 16'd0);
        power_switch       = 1'b1;
        floor_call_buttons = '0;
        step_cycle();
        check_equal("door permit at stop", 16'(door_open_allowed), 16'd1);

        for (int cycle = 0; cycle < 3000; cycle++) begin
            drive_random_inputs();
            // Dispatcher outputs follow the new inputs before the lamps move
            #1;
            check_outputs();
            step_cycle();
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
